// ==== verilog/resp_bank_pkg.sv ====
/*
 * Sizes and width types for the response reorder bank.
 * Every RTL block imports this package, and so does the testbench.
 */
package resp_bank_pkg;

  //////////////////////////////
  // Bank dimensions
  //////////////////////////////

  localparam int bank_slots     = 8;
  localparam int num_ids        = 4;
  localparam int payload_width  = 16;

  // Derived address widths
  localparam int slot_idx_width = $clog2(bank_slots);
  localparam int id_width       = $clog2(num_ids);

  //////////////////////////////
  // Width types
  //////////////////////////////

  // Binary slot address
  typedef logic [slot_idx_width-1:0] slot_idx_t;
  // One bit per slot (occupancy, release enable, released one-hot)
  typedef logic [bank_slots-1:0]     slot_mask_t;
  // Binary AXI identifier
  typedef logic [id_width-1:0]       axi_id_t;
  // One bit per identifier
  typedef logic [num_ids-1:0]        id_mask_t;
  // Response payload without the identifier
  typedef logic [payload_width-1:0]  payload_t;
  // One slot address per identifier, packed
  typedef slot_idx_t [num_ids-1:0]   id_slots_t;

endpackage

// ==== verilog/free_slot_alloc.sv ====
/*
 * Slot occupancy tracker for the reorder bank.
 * Offers the lowest free slot to the next reservation and frees the
 * slot that leaves through the output handshake.
 */
`timescale 1ns/1ps

module free_slot_alloc (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      i_alloc,
  input  resp_bank_pkg::slot_mask_t i_free_onehot,
  output resp_bank_pkg::slot_idx_t  o_free_slot,
  output logic                      o_not_full
);
  import resp_bank_pkg::*;

  slot_mask_t occ_q;
  slot_mask_t occ_d;
  slot_mask_t free_first;
  slot_mask_t alloc_onehot;
  logic       alloc_fire;

  //////////////////////////////
  // Lowest free slot
  //////////////////////////////

  // Priority chain, a slot wins when it is free and all below are taken
  assign free_first[0] = ~occ_q[0];
  for (genvar g = 1; g < bank_slots; g++) begin : g_free_chain
    assign free_first[g] = ~occ_q[g] && (&occ_q[g-1:0]);
  end

  // One-hot to binary
  always_comb begin
    o_free_slot = '0;
    for (int i = 0; i < bank_slots; i++) begin
      if (free_first[i]) begin
        o_free_slot = slot_idx_t'(i);
      end
    end
  end

  assign o_not_full = ~(&occ_q);

  //////////////////////////////
  // Occupancy update
  //////////////////////////////

  // Reservation handshake
  assign alloc_fire   = i_alloc && o_not_full;
  assign alloc_onehot = slot_mask_t'(alloc_fire) << o_free_slot;

  // Allocated and released slots never overlap
  assign occ_d = (occ_q | alloc_onehot) & ~i_free_onehot;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

endmodule

// ==== verilog/id_queue_ctrl.sv ====
/*
 * Per-identifier linked lists threaded through the shared slot pool.
 * Tracks reservation, fill and release pointers for each AXI identifier
 * and accepts a response only when its identifier has an unfilled slot.
 */
`timescale 1ns/1ps

module id_queue_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      i_rsv_fire,
  input  resp_bank_pkg::id_mask_t   i_rsv_id_onehot,
  input  resp_bank_pkg::slot_idx_t  i_new_slot,
  input  logic                      i_in_valid,
  input  resp_bank_pkg::axi_id_t    i_in_id,
  output logic                      o_in_ready,
  output logic                      o_fill_we,
  output resp_bank_pkg::slot_idx_t  o_fill_slot,
  input  logic                      i_out_fire,
  input  resp_bank_pkg::axi_id_t    i_out_id,
  output resp_bank_pkg::id_slots_t  o_out_slots,
  output resp_bank_pkg::id_mask_t   o_nonempty
);
  import resp_bank_pkg::*;

  // Entry count, up to the whole bank
  typedef logic [$clog2(bank_slots + 1)-1:0] cnt_t;

  // Last reserved, next to fill and next to release
  slot_idx_t last_q [num_ids];
  slot_idx_t last_d [num_ids];
  slot_idx_t fill_q [num_ids];
  slot_idx_t fill_d [num_ids];
  slot_idx_t out_q  [num_ids];
  slot_idx_t out_d  [num_ids];

  // Reserved-unfilled and filled-unreleased counts
  cnt_t rsv_cnt_q [num_ids];
  cnt_t rsv_cnt_d [num_ids];
  cnt_t rsp_cnt_q [num_ids];
  cnt_t rsp_cnt_d [num_ids];
  cnt_t rsp_left  [num_ids];

  id_mask_t rsv_hit;
  id_mask_t fill_hit;
  id_mask_t out_hit;
  id_mask_t outstanding;

  // Link memory, next slot of the same identifier
  slot_idx_t link_mem [bank_slots];
  logic      link_we;
  slot_idx_t link_addr;
  logic      in_fire;

  assign o_in_ready  = i_in_valid && (rsv_cnt_q[i_in_id] != '0);
  assign in_fire     = i_in_valid && o_in_ready;
  assign o_fill_we   = in_fire;
  assign o_fill_slot = fill_q[i_in_id];

  //////////////////////////////
  // Pointer and count update
  //////////////////////////////

  always_comb begin
    link_we   = 1'b0;
    link_addr = '0;
    for (int i = 0; i < num_ids; i++) begin
      rsv_hit[i]  = i_rsv_fire && i_rsv_id_onehot[i];
      fill_hit[i] = in_fire && (i_in_id == axi_id_t'(i));
      out_hit[i]  = i_out_fire && (i_out_id == axi_id_t'(i));

      // Queue state once a release in this cycle is taken out
      rsp_left[i]    = rsp_cnt_q[i] - cnt_t'(out_hit[i]);
      outstanding[i] = (rsv_cnt_q[i] != '0) || (rsp_left[i] != '0);

      rsv_cnt_d[i] = rsv_cnt_q[i] + cnt_t'(rsv_hit[i]) - cnt_t'(fill_hit[i]);
      rsp_cnt_d[i] = rsp_left[i] + cnt_t'(fill_hit[i]);
      last_d[i]    = rsv_hit[i] ? i_new_slot : last_q[i];

      // New slot goes behind the last one if the list survives
      if (rsv_hit[i] && outstanding[i]) begin
        link_we   = 1'b1;
        link_addr = last_q[i];
      end

      fill_d[i] = fill_q[i];
      if (rsv_hit[i] && ((rsv_cnt_q[i] == '0) ||
          (fill_hit[i] && rsv_cnt_q[i] == cnt_t'(1)))) begin
        fill_d[i] = i_new_slot;
      end else if (fill_hit[i] && rsv_cnt_q[i] > cnt_t'(1)) begin
        fill_d[i] = link_mem[fill_q[i]];
      end

      out_d[i] = out_q[i];
      if (rsv_hit[i] && !outstanding[i]) begin
        out_d[i] = i_new_slot;
      end else if (out_hit[i] && outstanding[i]) begin
        out_d[i] = link_mem[out_q[i]];
      end

      o_out_slots[i] = out_q[i];
      o_nonempty[i]  = rsp_cnt_q[i] != '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q    <= '{default: '0};
      fill_q    <= '{default: '0};
      out_q     <= '{default: '0};
      rsv_cnt_q <= '{default: '0};
      rsp_cnt_q <= '{default: '0};
    end else begin
      last_q    <= last_d;
      fill_q    <= fill_d;
      out_q     <= out_d;
      rsv_cnt_q <= rsv_cnt_d;
      rsp_cnt_q <= rsp_cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (link_we) begin
      link_mem[link_addr] <= i_new_slot;
    end
  end

endmodule

// ==== verilog/payload_store.sv ====
/*
 * Payload storage, one entry per bank slot.
 * Written by the response input, read at the slot held for output.
 */
`timescale 1ns/1ps

module payload_store (
  input  logic                      clk_i,
  input  logic                      i_we,
  input  resp_bank_pkg::slot_idx_t  i_wr_slot,
  input  resp_bank_pkg::slot_idx_t  i_rd_slot,
  input  resp_bank_pkg::payload_t   i_wdata,
  output resp_bank_pkg::payload_t   o_rdata
);
  import resp_bank_pkg::*;

  payload_t mem [bank_slots];

  //////////////////////////////
  // Write port
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (i_we) begin
      mem[i_wr_slot] <= i_wdata;
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////

  // Combinational, follows the held output slot
  assign o_rdata = mem[i_rd_slot];

endmodule

// ==== verilog/release_arbiter.sv ====
/*
 * Output selection for the reorder bank.
 * Loads the lowest eligible identifier into the output register when it
 * is empty and drives the output handshake and the released slot mask.
 */
`timescale 1ns/1ps

module release_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  resp_bank_pkg::id_mask_t   i_nonempty,
  input  resp_bank_pkg::id_slots_t  i_out_slots,
  input  resp_bank_pkg::slot_mask_t i_release_en,
  input  logic                      i_out_ready,
  output logic                      o_out_valid,
  output resp_bank_pkg::axi_id_t    o_out_id,
  output resp_bank_pkg::slot_idx_t  o_out_slot,
  output logic                      o_out_fire,
  output resp_bank_pkg::slot_mask_t o_released_onehot
);
  import resp_bank_pkg::*;

  id_mask_t  eligible;
  logic      pick_valid;
  axi_id_t   pick_id;
  slot_idx_t pick_slot;

  //////////////////////////////
  // Candidate selection
  //////////////////////////////

  // Head of the queue must be filled and enabled
  for (genvar g = 0; g < num_ids; g++) begin : g_eligible
    assign eligible[g] = i_nonempty[g] && i_release_en[i_out_slots[g]];
  end

  // Lowest identifier wins
  always_comb begin
    pick_valid = 1'b0;
    pick_id    = '0;
    for (int i = num_ids - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        pick_valid = 1'b1;
        pick_id    = axi_id_t'(i);
      end
    end
  end

  assign pick_slot = i_out_slots[pick_id];

  //////////////////////////////
  // Output register
  //////////////////////////////

  assign o_out_fire = o_out_valid && i_out_ready;

  // Loads only while empty, so a handshake leaves one idle cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      o_out_valid <= 1'b0;
      o_out_id    <= '0;
      o_out_slot  <= '0;
    end else if (!o_out_valid) begin
      o_out_valid <= pick_valid;
      o_out_id    <= pick_id;
      o_out_slot  <= pick_slot;
    end else if (o_out_fire) begin
      o_out_valid <= 1'b0;
    end
  end

  assign o_released_onehot = slot_mask_t'(o_out_fire) << o_out_slot;

endmodule

// ==== verilog/resp_bank.sv ====
/*
 * Response reorder bank top level.
 * Slots are reserved per AXI identifier, filled by the memory controller
 * and released in reservation order once enabled by the requester.
 */
`timescale 1ns/1ps

module resp_bank (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Reservation
  input  logic                      i_rsv_valid,
  input  resp_bank_pkg::id_mask_t   i_rsv_id_onehot,
  output logic                      o_rsv_ready,
  output resp_bank_pkg::slot_idx_t  o_rsv_addr,
  // Response input from the memory controller
  input  logic                      i_in_valid,
  input  resp_bank_pkg::axi_id_t    i_in_id,
  input  resp_bank_pkg::payload_t   i_in_data,
  output logic                      o_in_ready,
  // Release control
  input  resp_bank_pkg::slot_mask_t i_release_en,
  output resp_bank_pkg::slot_mask_t o_released_onehot,
  // Response output to the requester
  output logic                      o_out_valid,
  output resp_bank_pkg::axi_id_t    o_out_id,
  output resp_bank_pkg::payload_t   o_out_data,
  input  logic                      i_out_ready
);
  import resp_bank_pkg::*;

  logic      rsv_fire;
  logic      fill_we;
  slot_idx_t fill_slot;
  id_slots_t out_slots;
  id_mask_t  nonempty;
  logic      out_fire;
  slot_idx_t out_slot;

  assign rsv_fire = i_rsv_valid && o_rsv_ready;

  free_slot_alloc u_free_slot_alloc (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .i_alloc       (i_rsv_valid),
    .i_free_onehot (o_released_onehot),
    .o_free_slot   (o_rsv_addr),
    .o_not_full    (o_rsv_ready)
  );

  id_queue_ctrl u_id_queue_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .i_rsv_fire      (rsv_fire),
    .i_rsv_id_onehot (i_rsv_id_onehot),
    .i_new_slot      (o_rsv_addr),
    .i_in_valid      (i_in_valid),
    .i_in_id         (i_in_id),
    .o_in_ready      (o_in_ready),
    .o_fill_we       (fill_we),
    .o_fill_slot     (fill_slot),
    .i_out_fire      (out_fire),
    .i_out_id        (o_out_id),
    .o_out_slots     (out_slots),
    .o_nonempty      (nonempty)
  );

  payload_store u_payload_store (
    .clk_i     (clk_i),
    .i_we      (fill_we),
    .i_wr_slot (fill_slot),
    .i_rd_slot (out_slot),
    .i_wdata   (i_in_data),
    .o_rdata   (o_out_data)
  );

  release_arbiter u_release_arbiter (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_nonempty        (nonempty),
    .i_out_slots       (out_slots),
    .i_release_en      (i_release_en),
    .i_out_ready       (i_out_ready),
    .o_out_valid       (o_out_valid),
    .o_out_id          (o_out_id),
    .o_out_slot        (out_slot),
    .o_out_fire        (out_fire),
    .o_released_onehot (o_released_onehot)
  );

endmodule

// ==== sim/tb_resp_bank_sva.sv ====
/*
 * Protocol assertions for the reorder bank, bound to the top level.
 * Covers reservation back-pressure, output stability and release pulses.
 */
`timescale 1ns/1ps

module resp_bank_sva (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      i_rsv_valid,
  input logic                      o_rsv_ready,
  input logic                      o_out_valid,
  input logic                      i_out_ready,
  input resp_bank_pkg::axi_id_t    o_out_id,
  input resp_bank_pkg::payload_t   o_out_data,
  input resp_bank_pkg::slot_mask_t o_released_onehot
);
  import resp_bank_pkg::*;

  // Slots in use, counted from the port handshakes
  logic [3:0] used_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      used_q <= '0;
    end else begin
      used_q <= used_q + 4'(i_rsv_valid && o_rsv_ready) - 4'(o_released_onehot != '0);
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !o_rsv_ready |-> (used_q == 4'(bank_slots)))
    else $error("reservation stalled while slots are free");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (o_out_valid && !i_out_ready) |=>
      (o_out_valid && $stable(o_out_id) && $stable(o_out_data)))
    else $error("output changed under back-pressure");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (o_released_onehot != '0) |->
      ($onehot(o_released_onehot) && o_out_valid && i_out_ready))
    else $error("release pulse without a single output handshake");

endmodule

bind resp_bank resp_bank_sva u_resp_bank_sva (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .i_rsv_valid       (i_rsv_valid),
  .o_rsv_ready       (o_rsv_ready),
  .o_out_valid       (o_out_valid),
  .i_out_ready       (i_out_ready),
  .o_out_id          (o_out_id),
  .o_out_data        (o_out_data),
  .o_released_onehot (o_released_onehot)
);

// ==== sim/tb_resp_bank.sv ====
/*
 * Directed testbench for the response reorder bank.
 * A reference model of per-identifier queues and slot usage predicts
 * reservation addresses, input acceptance and release order.
 */
`timescale 1ns/1ps

module tb_resp_bank;
  import resp_bank_pkg::*;

  localparam logic [31:0] lcg_seed   = 32'h5dd7a942;
  localparam int          wait_limit = 50;

  logic       clk;
  logic       rst_n;
  logic       i_rsv_valid;
  id_mask_t   i_rsv_id_onehot;
  logic       o_rsv_ready;
  slot_idx_t  o_rsv_addr;
  logic       i_in_valid;
  axi_id_t    i_in_id;
  payload_t   i_in_data;
  logic       o_in_ready;
  slot_mask_t i_release_en;
  slot_mask_t o_released_onehot;
  logic       o_out_valid;
  axi_id_t    o_out_id;
  payload_t   o_out_data;
  logic       i_out_ready;

  // Reference model with slots in reservation order and payloads in fill order
  slot_idx_t  slot_q [num_ids][$];
  payload_t   data_q [num_ids][$];
  slot_mask_t used_mask;

  logic [31:0] seed;
  int          errors;
  int          checks;

  resp_bank UUT (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .i_rsv_valid       (i_rsv_valid),
    .i_rsv_id_onehot   (i_rsv_id_onehot),
    .o_rsv_ready       (o_rsv_ready),
    .o_rsv_addr        (o_rsv_addr),
    .i_in_valid        (i_in_valid),
    .i_in_id           (i_in_id),
    .i_in_data         (i_in_data),
    .o_in_ready        (o_in_ready),
    .i_release_en      (i_release_en),
    .o_released_onehot (o_released_onehot),
    .o_out_valid       (o_out_valid),
    .o_out_id          (o_out_id),
    .o_out_data        (o_out_data),
    .i_out_ready       (i_out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic slot_idx_t lowest_free();
    slot_idx_t found;
    found = '0;
    for (int i = bank_slots - 1; i >= 0; i--) begin
      if (!used_mask[i]) begin
        found = slot_idx_t'(i);
      end
    end
    return found;
  endfunction

  // Lowest identifier whose head is filled and enabled or -1 when there is none
  function automatic int pick_expected_id();
    int found;
    found = -1;
    for (int i = num_ids - 1; i >= 0; i--) begin
      if (data_q[i].size() != 0 && i_release_en[slot_q[i][0]]) begin
        found = i;
      end
    end
    return found;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s expected 0x%0h got 0x%0h", name, exp, got);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    $display("%s: %0d errors", name, errors - err0);
  endtask

  //////////////////////////////
  // Bus tasks
  //////////////////////////////

  // All bus tasks start and end on a falling edge
  task automatic reserve(input axi_id_t id, output slot_idx_t slot);
    int        n;
    slot_idx_t exp_slot;
    n = 0;
    slot = '0;
    i_rsv_valid     = 1'b1;
    i_rsv_id_onehot = id_mask_t'(1) << id;
    #1;
    while (!o_rsv_ready && n < wait_limit) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (o_rsv_ready) begin
      exp_slot = lowest_free();
      check_value("o_rsv_addr", 32'(o_rsv_addr), 32'(exp_slot));
      slot = o_rsv_addr;
      used_mask[exp_slot] = 1'b1;
      slot_q[id].push_back(exp_slot);
    end else begin
      errors++;
      $display("Timed out waiting for o_rsv_ready on identifier %0d", id);
    end
    @(negedge clk);
    i_rsv_valid = 1'b0;
  endtask

  task automatic fill(input axi_id_t id, input payload_t data);
    logic exp_ready;
    exp_ready  = slot_q[id].size() > data_q[id].size();
    i_in_valid = 1'b1;
    i_in_id    = id;
    i_in_data  = data;
    #1;
    check_value("o_in_ready", 32'(o_in_ready), 32'(exp_ready));
    if (o_in_ready && exp_ready) begin
      data_q[id].push_back(data);
    end
    @(negedge clk);
    i_in_valid = 1'b0;
  endtask

  // Takes one response after holding back-pressure for a number of cycles
  task automatic drain_one(input int hold);
    int        n;
    int        exp_id;
    slot_idx_t slot;
    n = 0;
    while (!o_out_valid && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!o_out_valid) begin
      errors++;
      $display("Timed out waiting for o_out_valid");
      return;
    end
    exp_id = pick_expected_id();
    if (exp_id < 0) begin
      errors++;
      $display("Output appeared with no eligible response in the model");
      return;
    end
    slot = slot_q[exp_id][0];
    check_value("o_out_id", 32'(o_out_id), 32'(exp_id));
    check_value("o_out_data", 32'(o_out_data), 32'(data_q[exp_id][0]));
    repeat (hold) begin
      @(negedge clk);
      check_value("o_out_valid", 32'(o_out_valid), 32'd1);
      check_value("o_out_id", 32'(o_out_id), 32'(exp_id));
      check_value("o_out_data", 32'(o_out_data), 32'(data_q[exp_id][0]));
    end
    i_out_ready = 1'b1;
    #1;
    check_value("o_released_onehot", 32'(o_released_onehot),
                32'(slot_mask_t'(1) << slot));
    @(negedge clk);
    i_out_ready = 1'b0;
    void'(slot_q[exp_id].pop_front());
    void'(data_q[exp_id].pop_front());
    used_mask[slot] = 1'b0;
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_reset_alloc();
    int        err0;
    slot_idx_t slot;
    err0 = errors;
    check_value("o_rsv_ready", 32'(o_rsv_ready), 32'd1);
    check_value("o_out_valid", 32'(o_out_valid), 32'd0);
    for (int i = 0; i < 3; i++) begin
      reserve(axi_id_t'(0), slot);
      check_value("o_rsv_addr", 32'(slot), 32'(i));
    end
    i_release_en = '1;
    for (int i = 0; i < 3; i++) begin
      fill(axi_id_t'(0), payload_t'(lcg_next()));
    end
    repeat (3) drain_one(0);
    i_release_en = '0;
    report_test("reset and allocation", err0);
  endtask

  task automatic test_single_id();
    int        err0;
    slot_idx_t slot;
    err0 = errors;
    i_release_en = '1;
    for (int i = 0; i < 4; i++) begin
      reserve(axi_id_t'(2), slot);
    end
    for (int i = 0; i < 4; i++) begin
      fill(axi_id_t'(2), payload_t'(lcg_next()));
    end
    repeat (4) drain_one(0);
    i_release_en = '0;
    report_test("single identifier order", err0);
  endtask

  task automatic test_interleaved();
    int        err0;
    int        start;
    int        cand;
    slot_idx_t slot;
    err0 = errors;
    i_release_en = '0;
    for (int r = 0; r < 2; r++) begin
      for (int id = 0; id < num_ids; id++) begin
        reserve(axi_id_t'(id), slot);
      end
    end
    // Shuffled fill order that searches up from a random identifier
    for (int k = 0; k < 8; k++) begin
      start = int'(lcg_next() % 32'(num_ids));
      for (int j = 0; j < num_ids; j++) begin
        cand = (start + j) % num_ids;
        if (slot_q[cand].size() > data_q[cand].size()) begin
          break;
        end
      end
      fill(axi_id_t'(cand), payload_t'(lcg_next()));
    end
    i_release_en = '1;
    repeat (8) drain_one(0);
    i_release_en = '0;
    report_test("interleaved identifiers", err0);
  endtask

  task automatic test_full_bank();
    int        err0;
    slot_idx_t slot;
    slot_idx_t freed;
    err0 = errors;
    i_release_en = '0;
    // Nothing reserved for this identifier yet
    fill(axi_id_t'(3), 16'h0bad);
    for (int i = 0; i < bank_slots; i++) begin
      reserve(axi_id_t'(i % num_ids), slot);
    end
    check_value("o_rsv_ready", 32'(o_rsv_ready), 32'd0);
    for (int i = 0; i < bank_slots; i++) begin
      fill(axi_id_t'(i % num_ids), payload_t'(lcg_next()));
    end
    freed        = slot_q[1][0];
    i_release_en = slot_mask_t'(1) << freed;
    drain_one(0);
    reserve(axi_id_t'(3), slot);
    check_value("o_rsv_addr", 32'(slot), 32'(freed));
    fill(axi_id_t'(3), payload_t'(lcg_next()));
    i_release_en = '1;
    repeat (bank_slots) drain_one(0);
    i_release_en = '0;
    report_test("full bank and reuse", err0);
  endtask

  task automatic test_gating_backpressure();
    int        err0;
    slot_idx_t slot;
    err0 = errors;
    i_release_en = '0;
    reserve(axi_id_t'(1), slot);
    fill(axi_id_t'(1), payload_t'(lcg_next()));
    // A filled but disabled slot must stay inside the bank
    repeat (8) begin
      @(negedge clk);
      check_value("o_out_valid", 32'(o_out_valid), 32'd0);
    end
    i_release_en = slot_mask_t'(1) << slot;
    drain_one(4);
    i_release_en = '0;
    report_test("release gating and back-pressure", err0);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    seed            = lcg_seed;
    errors          = 0;
    checks          = 0;
    used_mask       = '0;
    i_rsv_valid     = 1'b0;
    i_rsv_id_onehot = '0;
    i_in_valid      = 1'b0;
    i_in_id         = '0;
    i_in_data       = '0;
    i_release_en    = '0;
    i_out_ready     = 1'b0;
    rst_n           = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_reset_alloc();
    test_single_id();
    test_interleaved();
    test_full_bank();
    test_gating_backpressure();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
verilog/resp_bank_pkg.sv
verilog/free_slot_alloc.sv
verilog/id_queue_ctrl.sv
verilog/payload_store.sv
verilog/release_arbiter.sv
verilog/resp_bank.sv
sim/tb_resp_bank_sva.sv
sim/tb_resp_bank.sv

// ==== Makefile ====
# Verilator build for the response reorder bank testbench

TOP = tb_resp_bank

.PHONY: compile run clean

compile:
	verilator --binary --assert --top-module $(TOP) -f sources.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
